// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vtb_id_stage
	@out="$$(./obj_dir/Vtb_id_stage)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/Vtb_id_stage: project.f $(wildcard src/*.sv dv/*.sv)
	verilator --binary --assert --timescale 1ns/1ns --top-module tb_id_stage -f project.f

clean:
	rm -rf obj_dir

// ==== dv/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== dv/tb_id_stage.sv ====
module tb_id_stage
    import id_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    // limit covers about 1150 stimulus cycles plus margin
    localparam int MAX_CYCLES = 3000;
    localparam int KINDS      = 41;

    localparam logic [5:0] FUNCTS [18] = '{
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h20,
        6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
    };
    localparam logic [5:0] OPCODES [16] = '{
        6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09,
        6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b
    };
    localparam logic [4:0] REGIMM_RT [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

    logic        clk;
    logic        rst;
    stall_t      stall;
    if_id_t      if_id;
    logic [31:0] inst_rdata;
    fwd_t        ex_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    logic        ex_is_load;
    id_ex_t      id_ex;
    br_t         br;
    logic        stall_req;

    int          seed        = 15;
    int          cycles      = 0;
    int          decode_errs = 0;
    int          pipe_errs   = 0;
    int          oper_errs   = 0;
    int          branch_errs = 0;
    int          stall_errs  = 0;
    string       test_name   = "reset";
    logic [31:0] next_word   = '0;

    // reference model state
    if_id_t      m_slot;
    logic        m_held_en;
    logic [31:0] m_held_inst;
    logic [31:0] m_inst;
    logic [31:0] shadow [32];
    ctrl_t       exp_ctrl;
    logic [31:0] exp_rd1;
    logic [31:0] exp_rd2;
    br_t         exp_br;
    logic        exp_stall;
    logic [16:0] exp_ctrl_bits;
    logic [16:0] act_ctrl_bits;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    id_stage UUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id      (if_id),
        .inst_rdata (inst_rdata),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .id_ex      (id_ex),
        .br         (br),
        .stall_req  (stall_req)
    );

    // expected controls from the ISA encoding
    function automatic ctrl_t decode_ctrl(logic valid, logic [31:0] w);
        ctrl_t      c;
        logic [5:0] op;
        logic [5:0] fn;
        c  = '0;
        op = w[31:26];
        fn = w[5:0];
        if (!valid) begin
            return c;
        end
        case (op)
            6'h00: begin
                case (fn)
                    6'h00, 6'h04: c.alu_op = ALU_SLL;
                    6'h02, 6'h06: c.alu_op = ALU_SRL;
                    6'h03, 6'h07: c.alu_op = ALU_SRA;
                    6'h08:        c.br_op = BR_JR;
                    6'h09:        c.br_op = BR_JALR;
                    6'h20, 6'h21: c.alu_op = ALU_ADD;
                    6'h22, 6'h23: c.alu_op = ALU_SUB;
                    6'h24:        c.alu_op = ALU_AND;
                    6'h25:        c.alu_op = ALU_OR;
                    6'h26:        c.alu_op = ALU_XOR;
                    6'h27:        c.alu_op = ALU_NOR;
                    6'h2a:        c.alu_op = ALU_SLT;
                    6'h2b:        c.alu_op = ALU_SLTU;
                    default:      c.alu_op = ALU_NONE;
                endcase
                if (c.alu_op != ALU_NONE) begin
                    c.rf_we    = 1'b1;
                    c.rf_waddr = w[15:11];
                end
                if (fn inside {6'h00, 6'h02, 6'h03}) c.src1 = SRC1_SA;
            end
            6'h01: begin
                case (w[20:16])
                    5'h00:   c.br_op = BR_BLTZ;
                    5'h01:   c.br_op = BR_BGEZ;
                    5'h10:   c.br_op = BR_BLTZAL;
                    5'h11:   c.br_op = BR_BGEZAL;
                    default: c.br_op = BR_NONE;
                endcase
            end
            6'h02: c.br_op = BR_J;
            6'h03: c.br_op = BR_JAL;
            6'h04: c.br_op = BR_BEQ;
            6'h05: c.br_op = BR_BNE;
            6'h06: c.br_op = BR_BLEZ;
            6'h07: c.br_op = BR_BGTZ;
            6'h08, 6'h09: begin
                c.alu_op = ALU_ADD;
                c.src2   = SRC2_SIMM;
            end
            6'h0a: begin
                c.alu_op = ALU_SLT;
                c.src2   = SRC2_SIMM;
            end
            6'h0b: begin
                c.alu_op = ALU_SLTU;
                c.src2   = SRC2_SIMM;
            end
            6'h0c: begin
                c.alu_op = ALU_AND;
                c.src2   = SRC2_ZIMM;
            end
            6'h0d: begin
                c.alu_op = ALU_OR;
                c.src2   = SRC2_ZIMM;
            end
            6'h0e: begin
                c.alu_op = ALU_XOR;
                c.src2   = SRC2_ZIMM;
            end
            6'h0f: begin
                c.alu_op = ALU_LUI;
                c.src2   = SRC2_SIMM;
            end
            6'h23: begin
                c.alu_op   = ALU_ADD;
                c.src2     = SRC2_SIMM;
                c.mem_en   = 1'b1;
                c.sel_load = 1'b1;
            end
            6'h2b: begin
                c.alu_op = ALU_ADD;
                c.src2   = SRC2_SIMM;
                c.mem_en = 1'b1;
                c.mem_we = 1'b1;
            end
            default: c = '0;
        endcase
        if (op inside {[6'h08:6'h0f], 6'h23}) begin
            c.rf_we    = 1'b1;
            c.rf_waddr = w[20:16];
        end
        // linking forms write pc+8
        if (c.br_op inside {BR_JAL, BR_JALR, BR_BLTZAL, BR_BGEZAL}) begin
            c.alu_op   = ALU_ADD;
            c.src1     = SRC1_PC;
            c.src2     = SRC2_EIGHT;
            c.rf_we    = 1'b1;
            c.rf_waddr = (c.br_op == BR_JALR) ? w[15:11] : 5'd31;
        end
        return c;
    endfunction

    // later writes override earlier ones
    function automatic logic [31:0] bypass_value(logic [4:0] addr, logic [31:0] arr,
                                                 fwd_t ex, fwd_t mem, fwd_t wb);
        logic [31:0] v;
        v = arr;
        if (wb.we && wb.waddr == addr) v = wb.wdata;
        if (mem.we && mem.waddr == addr) v = mem.wdata;
        if (ex.we && ex.waddr == addr) v = ex.wdata;
        if (addr == 5'd0) v = '0;
        return v;
    endfunction

    function automatic br_t resolve_branch(br_op_e op, logic [31:0] pc, logic [31:0] w,
                                           logic [31:0] a, logic [31:0] b);
        br_t         r;
        logic [31:0] pc4;
        pc4      = pc + 32'd4;
        r.taken  = 1'b0;
        r.target = pc4 + (32'($signed(w[15:0])) << 2);
        case (op)
            BR_BEQ:             r.taken = (a == b);
            BR_BNE:             r.taken = (a != b);
            BR_BGEZ, BR_BGEZAL: r.taken = ($signed(a) >= 0);
            BR_BLTZ, BR_BLTZAL: r.taken = ($signed(a) < 0);
            BR_BGTZ:            r.taken = ($signed(a) > 0);
            BR_BLEZ:            r.taken = ($signed(a) <= 0);
            BR_J, BR_JAL: begin
                r.taken  = 1'b1;
                r.target = {pc4[31:28], w[25:0], 2'b00};
            end
            BR_JR, BR_JALR: begin
                r.taken  = 1'b1;
                r.target = a;
            end
            default:            r.taken = 1'b0;
        endcase
        if (!r.taken) r.target = '0;
        return r;
    endfunction

    // kinds 38 to 40 are words the decoder must ignore
    function automatic logic [31:0] make_word(int k, logic [31:0] r);
        if (k < 18) return {6'h00, r[25:6], FUNCTS[k]};
        if (k < 34) return {OPCODES[k-18], r[25:0]};
        if (k < 38) return {6'h01, r[25:21], REGIMM_RT[k-34], r[15:0]};
        if (k == 38) return {6'h3f, r[25:0]};
        if (k == 39) return {6'h00, r[25:6], 6'h3f};
        return {6'h01, r[25:21], 5'h1f, r[15:0]};
    endfunction

    function automatic fwd_t rand_fwd(logic narrow);
        fwd_t        f;
        logic [31:0] r;
        r       = $random(seed);
        f.we    = r[0];
        f.waddr = narrow ? {3'b000, r[2:1]} : r[7:3];
        // fixed values make equal and zero operands likely
        case (r[9:8])
            2'd0:    f.wdata = '0;
            2'd1:    f.wdata = 32'd1;
            2'd2:    f.wdata = '1;
            default: f.wdata = $random(seed);
        endcase
        return f;
    endfunction

    // word handed to fetch now shows up on inst_rdata one cycle later
    task automatic drive_cycle(input logic narrow, input logic with_stall);
        logic [31:0] r;
        logic [31:0] p;
        logic [31:0] w;
        int          k;
        r = $random(seed);
        p = $random(seed);
        p[1:0] = 2'b00;
        k = r[15:0] % KINDS;
        w = make_word(k, $random(seed));
        if (narrow) begin
            w[25:23] = 3'b000;
            if (w[31:26] != 6'h01) w[20:18] = 3'b000;
        end
        @(posedge clk);
        if_id      <= '{ce: (r[18:16] != 3'b000), pc: p};
        inst_rdata <= next_word;
        next_word  = w;
        ex_fwd     <= rand_fwd(narrow);
        mem_fwd    <= rand_fwd(narrow);
        wb_fwd     <= rand_fwd(narrow);
        ex_is_load <= r[20];
        stall      <= with_stall ? stall_t'(r[22:21]) : '0;
    endtask

    // IF/ID register, held word and register file of the model
    always @(posedge clk) begin
        if (rst) begin
            m_slot    <= '0;
            m_held_en <= 1'b0;
        end else begin
            if (stall.if_stop && !stall.id_stop) begin
                m_slot <= '0;
            end else if (!stall.if_stop) begin
                m_slot <= if_id;
            end
            m_held_en <= stall.if_stop;
        end
        if (stall.if_stop) m_held_inst <= m_inst;
        if (wb_fwd.we && wb_fwd.waddr != 5'd0) shadow[wb_fwd.waddr] <= wb_fwd.wdata;
    end

    always_comb begin
        m_inst    = m_held_en ? m_held_inst : inst_rdata;
        exp_ctrl  = decode_ctrl(m_slot.ce, m_inst);
        exp_rd1   = bypass_value(m_inst[25:21], shadow[m_inst[25:21]], ex_fwd, mem_fwd, wb_fwd);
        exp_rd2   = bypass_value(m_inst[20:16], shadow[m_inst[20:16]], ex_fwd, mem_fwd, wb_fwd);
        exp_br    = resolve_branch(exp_ctrl.br_op, m_slot.pc, m_inst, exp_rd1, exp_rd2);
        exp_stall = ex_is_load && ex_fwd.we && ex_fwd.waddr != 5'd0
                    && (ex_fwd.waddr == m_inst[25:21] || ex_fwd.waddr == m_inst[20:16]);
        exp_ctrl_bits = {exp_ctrl.alu_op, exp_ctrl.src1, exp_ctrl.src2, exp_ctrl.mem_en,
                         exp_ctrl.mem_we, exp_ctrl.rf_we, exp_ctrl.rf_waddr, exp_ctrl.sel_load};
        act_ctrl_bits = {id_ex.alu_op, id_ex.src1, id_ex.src2, id_ex.mem_en,
                         id_ex.mem_we, id_ex.rf_we, id_ex.rf_waddr, id_ex.sel_load};
    end

    ctrl_chk: assert property (@(posedge clk) disable iff (rst)
        act_ctrl_bits === exp_ctrl_bits)
    else begin
        decode_errs++;
        $display("ERR %s ctrl expected %h actual %h", test_name,
                 $sampled(exp_ctrl_bits), $sampled(act_ctrl_bits));
    end

    slot_chk: assert property (@(posedge clk) disable iff (rst)
        {id_ex.pc, id_ex.inst} === {m_slot.pc, m_inst})
    else begin
        pipe_errs++;
        $display("ERR %s pc/inst expected %h actual %h", test_name,
                 $sampled({m_slot.pc, m_inst}), $sampled({id_ex.pc, id_ex.inst}));
    end

    reset_chk: assert property (@(posedge clk)
        $past(rst) && !rst |-> id_ex.alu_op == ALU_NONE && !id_ex.rf_we
                               && !id_ex.mem_en && !id_ex.mem_we && !br.taken)
    else begin
        pipe_errs++;
        $display("controls still active in the first cycle after reset");
    end

    oper_chk: assert property (@(posedge clk) disable iff (rst)
        {id_ex.rdata1, id_ex.rdata2} === {exp_rd1, exp_rd2})
    else begin
        oper_errs++;
        $display("ERR %s operands expected %h actual %h", test_name,
                 $sampled({exp_rd1, exp_rd2}), $sampled({id_ex.rdata1, id_ex.rdata2}));
    end

    branch_chk: assert property (@(posedge clk) disable iff (rst) br === exp_br)
    else begin
        branch_errs++;
        $display("ERR %s branch expected %h actual %h", test_name,
                 $sampled(exp_br), $sampled(br));
    end

    stall_chk: assert property (@(posedge clk) disable iff (rst) stall_req === exp_stall)
    else begin
        stall_errs++;
        $display("ERR %s stall_req expected %b actual %b", test_name,
                 $sampled(exp_stall), $sampled(stall_req));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        stall      = '0;
        if_id      = '0;
        inst_rdata = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        wait (rst === 1'b0);

        // every register including register 0 gets a known value
        test_name = "rf_init";
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            wb_fwd <= '{we: 1'b1, waddr: 5'(i), wdata: $random(seed)};
        end

        test_name = "decode";
        repeat (500) drive_cycle(1'b0, 1'b0);
        test_name = "bypass";
        repeat (300) drive_cycle(1'b1, 1'b0);
        test_name = "stall";
        repeat (300) drive_cycle(1'b1, 1'b1);

        @(posedge clk);
        stall  <= '0;
        if_id  <= '0;
        ex_fwd <= '0;
        wb_fwd <= '0;
        repeat (3) @(posedge clk);

        total = decode_errs + pipe_errs + oper_errs + branch_errs + stall_errs;
        $display("errors: decode %0d, pipe %0d, operands %0d, branch %0d, stall %0d",
                 decode_errs, pipe_errs, oper_errs, branch_errs, stall_errs);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/id_pkg.sv
src/id_latch.sv
src/inst_decoder.sv
src/operand_fetch.sv
src/branch_unit.sv
src/id_stage.sv
dv/tb_clock.sv
dv/tb_id_stage.sv

// ==== src/branch_unit.sv ====
module branch_unit
    import id_pkg::*;
(
    input  br_op_e          br_op,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output br_t             br
);

    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] rel_target;
    logic [XLEN-1:0] abs_target;
    logic            rs_eq_rt;
    logic            rs_neg;
    logic            rs_zero;
    logic            taken;
    logic [XLEN-1:0] target;

    assign pc_plus_4  = pc + XLEN'(4);
    assign rel_target = pc_plus_4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    assign abs_target = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_eq_rt = (rdata1 == rdata2);
    assign rs_neg   = rdata1[XLEN-1];
    assign rs_zero  = (rdata1 == '0);

    always_comb begin
        taken  = 1'b0;
        target = rel_target;
        case (br_op)
            BR_BEQ:              taken = rs_eq_rt;
            BR_BNE:              taken = !rs_eq_rt;
            BR_BGEZ, BR_BGEZAL:  taken = !rs_neg;
            BR_BLTZ, BR_BLTZAL:  taken = rs_neg;
            BR_BGTZ:             taken = !rs_neg && !rs_zero;
            BR_BLEZ:             taken = rs_neg || rs_zero;
            BR_J, BR_JAL: begin
                taken  = 1'b1;
                target = abs_target;
            end
            BR_JR, BR_JALR: begin
                taken  = 1'b1;
                target = rdata1;
            end
            default:             taken = 1'b0;
        endcase
    end

    assign br.taken  = taken;
    assign br.target = taken ? target : '0;

endmodule

// ==== src/id_latch.sv ====
module id_latch
    import id_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  stall_t          stall,
    input  if_id_t          if_id,
    input  logic [XLEN-1:0] inst_rdata,
    output if_id_t          slot,
    output logic [XLEN-1:0] inst
);

    logic            held_en;
    logic [XLEN-1:0] held_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else if (stall.if_stop && !stall.id_stop) begin
            // bubble into decode
            slot <= '0;
        end else if (!stall.if_stop) begin
            slot <= if_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_en <= 1'b0;
        end else begin
            held_en <= stall.if_stop;
        end
    end

    // memory output moves on while fetch is stopped, so keep the word
    always_ff @(posedge clk) begin
        if (stall.if_stop) begin
            held_inst <= inst;
        end
    end

    assign inst = held_en ? held_inst : inst_rdata;

endmodule

// ==== src/id_pkg.sv ====
package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [REG_AW-1:0] LINK_REG = REG_AW'(31);

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // special group, inst[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // regimm group, selected by the rt field
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_EIGHT, SRC2_ZIMM} src2_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_BLTZAL, BR_BGEZAL, BR_J, BR_JAL, BR_JR, BR_JALR
    } br_op_e;

    typedef struct packed {
        logic if_stop;
        logic id_stop;
    } stall_t;

    typedef struct packed {
        logic            ce;
        logic [XLEN-1:0] pc;
    } if_id_t;

    // pending write of a later stage; WB also feeds the register file
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e           alu_op;
        src1_e             src1;
        src2_e             src2;
        logic              mem_en;
        logic              mem_we;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic              sel_load;
        br_op_e            br_op;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        alu_op:   ALU_NONE,
        src1:     SRC1_RS,
        src2:     SRC2_RT,
        mem_en:   1'b0,
        mem_we:   1'b0,
        rf_we:    1'b0,
        rf_waddr: '0,
        sel_load: 1'b0,
        br_op:    BR_NONE
    };

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        alu_op_e           alu_op;
        src1_e             src1;
        src2_e             src2;
        logic              mem_en;
        logic              mem_we;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic              sel_load;
        logic [XLEN-1:0]   rdata1;
        logic [XLEN-1:0]   rdata2;
    } id_ex_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_t;

endpackage

// ==== src/id_stage.sv ====
module id_stage
    import id_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  stall_t          stall,
    input  if_id_t          if_id,
    input  logic [XLEN-1:0] inst_rdata,
    input  fwd_t            ex_fwd,
    input  fwd_t            mem_fwd,
    input  fwd_t            wb_fwd,
    input  logic            ex_is_load,
    output id_ex_t          id_ex,
    output br_t             br,
    output logic            stall_req
);

    if_id_t          slot;
    logic [XLEN-1:0] inst;
    ctrl_t           ctrl;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    id_latch u_latch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id      (if_id),
        .inst_rdata (inst_rdata),
        .slot       (slot),
        .inst       (inst)
    );

    inst_decoder u_decoder (
        .valid (slot.ce),
        .inst  (inst),
        .ctrl  (ctrl)
    );

    operand_fetch u_operands (
        .clk        (clk),
        .rs         (inst[25:21]),
        .rt         (inst[20:16]),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .stall_req  (stall_req)
    );

    branch_unit u_branch (
        .br_op  (ctrl.br_op),
        .pc     (slot.pc),
        .inst   (inst),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .br     (br)
    );

    // bundle for execute
    assign id_ex = '{
        pc:       slot.pc,
        inst:     inst,
        alu_op:   ctrl.alu_op,
        src1:     ctrl.src1,
        src2:     ctrl.src2,
        mem_en:   ctrl.mem_en,
        mem_we:   ctrl.mem_we,
        rf_we:    ctrl.rf_we,
        rf_waddr: ctrl.rf_waddr,
        sel_load: ctrl.sel_load,
        rdata1:   rdata1,
        rdata2:   rdata2
    };

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder
    import id_pkg::*;
(
    input  logic            valid,
    input  logic [XLEN-1:0] inst,
    output ctrl_t           ctrl
);

    opcode_e           opcode;
    funct_e            funct;
    regimm_e           ri_code;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;

    assign opcode  = opcode_e'(inst[31:26]);
    assign funct   = funct_e'(inst[5:0]);
    assign ri_code = regimm_e'(inst[20:16]);
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];

    // immediate ALU op, result to rt
    function automatic ctrl_t imm_op(alu_op_e op, src2_e src2, logic [REG_AW-1:0] dst);
        ctrl_t c;
        c          = CTRL_NOP;
        c.alu_op   = op;
        c.src2     = src2;
        c.rf_we    = 1'b1;
        c.rf_waddr = dst;
        return c;
    endfunction

    // return address pc+8 computed in execute
    function automatic ctrl_t link_op(br_op_e op, logic [REG_AW-1:0] dst);
        ctrl_t c;
        c          = CTRL_NOP;
        c.alu_op   = ALU_ADD;
        c.src1     = SRC1_PC;
        c.src2     = SRC2_EIGHT;
        c.rf_we    = 1'b1;
        c.rf_waddr = dst;
        c.br_op    = op;
        return c;
    endfunction

    always_comb begin
        ctrl = CTRL_NOP;
        if (valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rd;
                    case (funct)
                        F_SLL: begin
                            ctrl.alu_op = ALU_SLL;
                            ctrl.src1   = SRC1_SA;
                        end
                        F_SRL: begin
                            ctrl.alu_op = ALU_SRL;
                            ctrl.src1   = SRC1_SA;
                        end
                        F_SRA: begin
                            ctrl.alu_op = ALU_SRA;
                            ctrl.src1   = SRC1_SA;
                        end
                        F_SLLV:         ctrl.alu_op = ALU_SLL;
                        F_SRLV:         ctrl.alu_op = ALU_SRL;
                        F_SRAV:         ctrl.alu_op = ALU_SRA;
                        F_ADD, F_ADDU:  ctrl.alu_op = ALU_ADD;
                        F_SUB, F_SUBU:  ctrl.alu_op = ALU_SUB;
                        F_AND:          ctrl.alu_op = ALU_AND;
                        F_OR:           ctrl.alu_op = ALU_OR;
                        F_XOR:          ctrl.alu_op = ALU_XOR;
                        F_NOR:          ctrl.alu_op = ALU_NOR;
                        F_SLT:          ctrl.alu_op = ALU_SLT;
                        F_SLTU:         ctrl.alu_op = ALU_SLTU;
                        F_JR: begin
                            ctrl       = CTRL_NOP;
                            ctrl.br_op = BR_JR;
                        end
                        F_JALR:  ctrl = link_op(BR_JALR, rd);
                        default: ctrl = CTRL_NOP;
                    endcase
                end
                OP_REGIMM: begin
                    case (ri_code)
                        RI_BLTZ:   ctrl.br_op = BR_BLTZ;
                        RI_BGEZ:   ctrl.br_op = BR_BGEZ;
                        RI_BLTZAL: ctrl = link_op(BR_BLTZAL, LINK_REG);
                        RI_BGEZAL: ctrl = link_op(BR_BGEZAL, LINK_REG);
                        default:   ctrl = CTRL_NOP;
                    endcase
                end
                OP_J:      ctrl.br_op = BR_J;
                OP_JAL:    ctrl = link_op(BR_JAL, LINK_REG);
                OP_BEQ:    ctrl.br_op = BR_BEQ;
                OP_BNE:    ctrl.br_op = BR_BNE;
                OP_BLEZ:   ctrl.br_op = BR_BLEZ;
                OP_BGTZ:   ctrl.br_op = BR_BGTZ;
                OP_ADDI:   ctrl = imm_op(ALU_ADD, SRC2_SIMM, rt);
                OP_ADDIU:  ctrl = imm_op(ALU_ADD, SRC2_SIMM, rt);
                OP_SLTI:   ctrl = imm_op(ALU_SLT, SRC2_SIMM, rt);
                OP_SLTIU:  ctrl = imm_op(ALU_SLTU, SRC2_SIMM, rt);
                OP_ANDI:   ctrl = imm_op(ALU_AND, SRC2_ZIMM, rt);
                OP_ORI:    ctrl = imm_op(ALU_OR, SRC2_ZIMM, rt);
                OP_XORI:   ctrl = imm_op(ALU_XOR, SRC2_ZIMM, rt);
                OP_LUI:    ctrl = imm_op(ALU_LUI, SRC2_SIMM, rt);
                OP_LW: begin
                    ctrl          = imm_op(ALU_ADD, SRC2_SIMM, rt);
                    ctrl.mem_en   = 1'b1;
                    ctrl.sel_load = 1'b1;
                end
                OP_SW: begin
                    ctrl.alu_op = ALU_ADD;
                    ctrl.src2   = SRC2_SIMM;
                    ctrl.mem_en = 1'b1;
                    ctrl.mem_we = 1'b1;
                end
                default: ctrl = CTRL_NOP;
            endcase
        end
    end

endmodule

// ==== src/operand_fetch.sv ====
module operand_fetch
    import id_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] rs,
    input  logic [REG_AW-1:0] rt,
    input  fwd_t              ex_fwd,
    input  fwd_t              mem_fwd,
    input  fwd_t              wb_fwd,
    input  logic              ex_is_load,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    output logic              stall_req
);

    logic [XLEN-1:0] regs [2**REG_AW];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wb_fwd.we && wb_fwd.waddr != '0) begin
            regs[wb_fwd.waddr] <= wb_fwd.wdata;
        end
    end

    function automatic logic hit(fwd_t f, logic [REG_AW-1:0] addr);
        return f.we && (f.waddr == addr);
    endfunction

    // youngest pending write wins
    function automatic logic [XLEN-1:0] read_port(
        logic [REG_AW-1:0] addr,
        logic [XLEN-1:0]   arr_val,
        fwd_t              ex,
        fwd_t              mem,
        fwd_t              wb
    );
        if (addr == '0) begin
            return '0;
        end else if (hit(ex, addr)) begin
            return ex.wdata;
        end else if (hit(mem, addr)) begin
            return mem.wdata;
        end else if (hit(wb, addr)) begin
            return wb.wdata;
        end
        return arr_val;
    endfunction

    assign rdata1 = read_port(rs, regs[rs], ex_fwd, mem_fwd, wb_fwd);
    assign rdata2 = read_port(rt, regs[rt], ex_fwd, mem_fwd, wb_fwd);

    // load in EX cannot be bypassed this cycle
    assign stall_req = ex_is_load && ex_fwd.we && (ex_fwd.waddr != '0)
                       && ((ex_fwd.waddr == rs) || (ex_fwd.waddr == rt));

endmodule
